// File: ahb_sram_subordinate.f
+incdir+rtl
+incdir+sim
rtl/ahb_sram_pkg.sv
rtl/ahb_burst_addr.sv
rtl/ahb_xfer_decode.sv
rtl/ahb_resp_fsm.sv
rtl/ahb_sram_array.sv
rtl/ahb_sram_subordinate.sv
sim/tb_ahb_sram_subordinate.sv

// File: sim/tb_ahb_sram_checks.svh
/*
  reference memory model with byte lane merge
  compare tasks for HRESP, HREADYout and read data
*/
`ifndef TB_AHB_SRAM_CHECKS_SVH
`define TB_AHB_SRAM_CHECKS_SVH

// ----------------------------------------
// reference memory
// ----------------------------------------
logic [`AHB_DATA_WIDTH-1:0] model_mem [`SRAM_DEPTH];

// all zero, as the array comes out of reset
task automatic model_clear();
  for (int i = 0; i < `SRAM_DEPTH; i++) begin
    model_mem[i] = '0;
  end
endtask

// lanes from the low address bits up, as many as the size has bytes
task automatic model_write(input logic [31:0] addr, input hsize_e size,
                           input logic [31:0] data);
  int first;
  int count;
  first = addr[1:0];
  count = 1 << size;
  for (int b = 0; b < 4; b++) begin
    if ((b >= first) && (b < first + count)) begin
      model_mem[addr[`SRAM_INDEX_WIDTH+1:2]][8*b +: 8] = data[8*b +: 8];
    end
  end
endtask

// whole word, whatever the read size
function automatic logic [31:0] model_read(input logic [31:0] addr);
  return model_mem[addr[`SRAM_INDEX_WIDTH+1:2]];
endfunction

// ----------------------------------------
// compare tasks
// ----------------------------------------
task automatic check_resp(input string name, input hresp_e exp, input hresp_e act);
  if (act !== exp) begin
    $display("Fail %s: HRESP expected %s, actual %s", name, exp.name(), act.name());
    stop_on_error();
  end
endtask

task automatic check_ready(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("Fail %s: HREADYout expected %b, actual %b", name, exp, act);
    stop_on_error();
  end
endtask

task automatic check_rdata(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
  if (act !== exp) begin
    $display("Fail %s: HRDATA expected %h, actual %h", name, exp, act);
    stop_on_error();
  end
endtask

`endif

// File: sim/tb_ahb_sram_subordinate.sv
/*
  testbench for the ahb-lite sram subordinate
  clock and reset, stimulus table applied in a loop, lcg write data, timeout
*/
`timescale 1ns/1ps
`default_nettype none
`include "ahb_sram_config.svh"

module tb_ahb_sram_subordinate;
  import ahb_sram_pkg::*;

  localparam int MAX_ENT = 64;

  // dut ports
  logic        HCLK;
  logic        HRESETn;
  logic        HSEL;
  logic [31:0] HADDR;
  htrans_e     HTRANS;
  logic        HWRITE;
  hsize_e      HSIZE;
  hburst_e     HBURST;
  logic [31:0] HWDATA;
  logic        HREADYin;
  logic [31:0] HRDATA;
  hresp_e      HRESP;
  logic        HREADYout;

  // stimulus table, one address phase per entry
  string       t_name  [MAX_ENT];
  htrans_e     t_trans [MAX_ENT];
  hburst_e     t_burst [MAX_ENT];
  hsize_e      t_size  [MAX_ENT];
  logic        t_write [MAX_ENT];
  logic [31:0] t_addr  [MAX_ENT];
  logic [31:0] t_wdata [MAX_ENT];
  hresp_e      t_resp  [MAX_ENT];
  logic [31:0] t_rdata [MAX_ENT];
  int          n_ent = 0;

  logic [31:0] lcg_state;
  int          cycles = 0;
  int          cycle_limit = 0;

  ahb_sram_subordinate UUT (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HBURST    (HBURST),
    .HWDATA    (HWDATA),
    .HREADYin  (HREADYin),
    .HRDATA    (HRDATA),
    .HRESP     (HRESP),
    .HREADYout (HREADYout)
  );

  // single subordinate system, ready loops straight back
  assign HREADYin = HREADYout;

  initial HCLK = 1'b0;
  always #10 HCLK = ~HCLK;

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  `include "tb_ahb_sram_checks.svh"

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------
  task automatic add_entry(input string name, input htrans_e tr, input hburst_e burst,
                           input hsize_e size, input logic wr, input logic [31:0] addr,
                           input hresp_e resp);
    t_name[n_ent]  = name;
    t_trans[n_ent] = tr;
    t_burst[n_ent] = burst;
    t_size[n_ent]  = size;
    t_write[n_ent] = wr;
    t_addr[n_ent]  = addr;
    t_resp[n_ent]  = resp;
    n_ent++;
  endtask

  // 32-bit lcg, numerical recipes constants
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic build_table();
    // unwritten words read back as zero
    add_entry("reset read 3c", NONSEQ, SINGLE, SIZE_WORD, 1'b0, 32'h3C, OKAY);
    add_entry("reset read 00", NONSEQ, SINGLE, SIZE_WORD, 1'b0, 32'h00, OKAY);
    // read right behind a write goes through the bypass
    add_entry("word write", NONSEQ, SINGLE, SIZE_WORD, 1'b1, 32'h10, OKAY);
    add_entry("bypass read", NONSEQ, SINGLE, SIZE_WORD, 1'b0, 32'h10, OKAY);
    // byte lanes merging into one word
    add_entry("byte lane1", NONSEQ, SINGLE, SIZE_BYTE, 1'b1, 32'h21, OKAY);
    add_entry("half lanes23", NONSEQ, SINGLE, SIZE_HALF, 1'b1, 32'h22, OKAY);
    add_entry("byte lane0", NONSEQ, SINGLE, SIZE_BYTE, 1'b1, 32'h20, OKAY);
    add_entry("merged read", NONSEQ, SINGLE, SIZE_WORD, 1'b0, 32'h20, OKAY);
    add_entry("half lanes01", NONSEQ, SINGLE, SIZE_HALF, 1'b1, 32'h24, OKAY);
    add_entry("byte lane3", NONSEQ, SINGLE, SIZE_BYTE, 1'b1, 32'h27, OKAY);
    add_entry("byte read", NONSEQ, SINGLE, SIZE_BYTE, 1'b0, 32'h25, OKAY);
    // incr4 write with a busy beat inside
    add_entry("incr4 beat0", NONSEQ, INCR4, SIZE_WORD, 1'b1, 32'h30, OKAY);
    add_entry("incr4 beat1", SEQ, INCR4, SIZE_WORD, 1'b1, 32'h34, OKAY);
    add_entry("incr4 busy", BUSY, INCR4, SIZE_WORD, 1'b1, 32'h38, OKAY);
    add_entry("incr4 beat2", SEQ, INCR4, SIZE_WORD, 1'b1, 32'h38, OKAY);
    add_entry("incr4 beat3", SEQ, INCR4, SIZE_WORD, 1'b1, 32'h3C, OKAY);
    // wrap8 read from mid-block, block is 0x20 to 0x3f
    add_entry("wrap8 beat0", NONSEQ, WRAP8, SIZE_WORD, 1'b0, 32'h30, OKAY);
    add_entry("wrap8 beat1", SEQ, WRAP8, SIZE_WORD, 1'b0, 32'h34, OKAY);
    add_entry("wrap8 beat2", SEQ, WRAP8, SIZE_WORD, 1'b0, 32'h38, OKAY);
    add_entry("wrap8 busy", BUSY, WRAP8, SIZE_WORD, 1'b0, 32'h3C, OKAY);
    add_entry("wrap8 beat3", SEQ, WRAP8, SIZE_WORD, 1'b0, 32'h3C, OKAY);
    add_entry("wrap8 beat4", SEQ, WRAP8, SIZE_WORD, 1'b0, 32'h20, OKAY);
    add_entry("wrap8 beat5", SEQ, WRAP8, SIZE_WORD, 1'b0, 32'h24, OKAY);
    add_entry("wrap8 beat6", SEQ, WRAP8, SIZE_WORD, 1'b0, 32'h28, OKAY);
    add_entry("wrap8 beat7", SEQ, WRAP8, SIZE_WORD, 1'b0, 32'h2C, OKAY);
    // bad transfers, several back to back
    add_entry("range write", NONSEQ, SINGLE, SIZE_WORD, 1'b1, 32'h100, ERROR);
    add_entry("range check", NONSEQ, SINGLE, SIZE_WORD, 1'b0, 32'h00, OKAY);
    add_entry("misaligned word", NONSEQ, SINGLE, SIZE_WORD, 1'b1, 32'h06, ERROR);
    add_entry("misaligned half", NONSEQ, SINGLE, SIZE_HALF, 1'b1, 32'h13, ERROR);
    add_entry("over-word size", NONSEQ, SINGLE, SIZE_DWORD, 1'b1, 32'h08, ERROR);
    add_entry("range read", NONSEQ, SINGLE, SIZE_WORD, 1'b0, 32'h200, ERROR);
    add_entry("misaligned check", NONSEQ, SINGLE, SIZE_WORD, 1'b0, 32'h04, OKAY);
    add_entry("half check", NONSEQ, SINGLE, SIZE_WORD, 1'b0, 32'h10, OKAY);
    add_entry("over-word check", NONSEQ, SINGLE, SIZE_WORD, 1'b0, 32'h08, OKAY);
    // incr burst running off the end of the array
    add_entry("incr tail beat0", NONSEQ, INCR, SIZE_WORD, 1'b1, 32'hF8, OKAY);
    add_entry("incr tail beat1", SEQ, INCR, SIZE_WORD, 1'b1, 32'hFC, OKAY);
    add_entry("incr tail beat2", SEQ, INCR, SIZE_WORD, 1'b1, 32'h100, ERROR);
    add_entry("incr tail read", NONSEQ, SINGLE, SIZE_WORD, 1'b0, 32'hFC, OKAY);
    add_entry("tail range check", NONSEQ, SINGLE, SIZE_WORD, 1'b0, 32'h00, OKAY);
    // idle tail lets the last data phase finish
    add_entry("idle end", IDLE, SINGLE, SIZE_WORD, 1'b0, 32'h00, OKAY);
    add_entry("idle end", IDLE, SINGLE, SIZE_WORD, 1'b0, 32'h00, OKAY);
  endtask

  // write data from the lcg, read words from the model in table order
  task automatic fill_expected();
    model_clear();
    for (int k = 0; k < n_ent; k++) begin
      t_wdata[k] = lcg_next();
      t_rdata[k] = '0;
      if ((t_trans[k] == NONSEQ || t_trans[k] == SEQ) && t_resp[k] == OKAY) begin
        if (t_write[k]) begin
          model_write(t_addr[k], t_size[k], t_wdata[k]);
        end else begin
          t_rdata[k] = model_read(t_addr[k]);
        end
      end
    end
  endtask

  // ----------------------------------------
  // timeout
  // ----------------------------------------
  always @(posedge HCLK) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the stimulus table did not finish within %0d cycles", cycle_limit);
      stop_on_error();
    end
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int   i;
    int   dp_idx;
    logic dp_valid;
    logic dp_first;
    HRESETn   = 1'b0;
    HSEL      = 1'b0;
    HADDR     = '0;
    HTRANS    = IDLE;
    HWRITE    = 1'b0;
    HSIZE     = SIZE_WORD;
    HBURST    = SINGLE;
    HWDATA    = '0;
    lcg_state = 32'd51;
    build_table();
    fill_expected();
    cycle_limit = 3 * n_ent + 20;

    repeat (2) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;
    HSEL    = 1'b1;
    check_ready("after reset", 1'b1, HREADYout);
    check_resp("after reset", OKAY, HRESP);
    check_rdata("after reset", 32'h0, HRDATA);

    i        = 0;
    dp_idx   = 0;
    dp_valid = 1'b0;
    dp_first = 1'b1;
    while (i < n_ent) begin
      @(posedge HCLK);
      #1;
      HTRANS = t_trans[i];
      HBURST = t_burst[i];
      HSIZE  = t_size[i];
      HWRITE = t_write[i];
      // seq beats carry an inverted address, the subordinate must step its own
      HADDR  = (t_trans[i] == SEQ) ? ~t_addr[i] : t_addr[i];
      HWDATA = dp_valid ? t_wdata[dp_idx] : 32'h0;

      // mid-cycle, outputs settled
      @(negedge HCLK);
      if (dp_valid && t_resp[dp_idx] == ERROR && dp_first) begin
        // first error cycle stalls the bus
        check_ready(t_name[dp_idx], 1'b0, HREADYout);
        check_resp(t_name[dp_idx], ERROR, HRESP);
        dp_first = 1'b0;
      end else if (dp_valid) begin
        check_ready(t_name[dp_idx], 1'b1, HREADYout);
        check_resp(t_name[dp_idx], t_resp[dp_idx], HRESP);
        if (!t_write[dp_idx] && t_resp[dp_idx] == OKAY) begin
          check_rdata(t_name[dp_idx], t_rdata[dp_idx], HRDATA);
        end
      end else begin
        // idle or busy data phase
        check_ready("idle data phase", 1'b1, HREADYout);
        check_resp("idle data phase", OKAY, HRESP);
      end

      // entry on the bus is taken at the next edge only when ready
      if (HREADYout) begin
        dp_valid = (t_trans[i] == NONSEQ) || (t_trans[i] == SEQ);
        dp_idx   = i;
        dp_first = 1'b1;
        i++;
      end
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/ahb_sram_subordinate.sv
/*
  ahb-lite sram subordinate top
  burst address, decode, error response and sram array
*/
`timescale 1ns/1ps
`default_nettype none
`include "ahb_sram_config.svh"

module ahb_sram_subordinate (
  input  wire                         HCLK,
  input  wire                         HRESETn,
  input  wire                         HSEL,
  input  wire [`AHB_ADDR_WIDTH-1:0]   HADDR,
  input  wire ahb_sram_pkg::htrans_e  HTRANS,
  input  wire                         HWRITE,
  input  wire ahb_sram_pkg::hsize_e   HSIZE,
  input  wire ahb_sram_pkg::hburst_e  HBURST,
  input  wire [`AHB_DATA_WIDTH-1:0]   HWDATA,
  input  wire                         HREADYin,
  output logic [`AHB_DATA_WIDTH-1:0]  HRDATA,
  output ahb_sram_pkg::hresp_e        HRESP,
  output logic                        HREADYout
);

  // address phase
  logic                         accept;
  logic [`AHB_ADDR_WIDTH-1:0]   beat_addr;
  logic                         err_start;
  logic                         rd_en;
  logic [`SRAM_INDEX_WIDTH-1:0] rd_index;
  // data phase write
  logic                         wr_en;
  logic [`SRAM_INDEX_WIDTH-1:0] wr_index;
  logic [3:0]                   wr_strobe;

  // ----------------------------------------
  // beat address and decode
  // ----------------------------------------
  ahb_burst_addr u_burst_addr (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .accept    (accept),
    .HTRANS    (HTRANS),
    .HBURST    (HBURST),
    .HSIZE     (HSIZE),
    .HADDR     (HADDR),
    .beat_addr (beat_addr)
  );

  ahb_xfer_decode u_xfer_decode (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HREADYin  (HREADYin),
    .beat_addr (beat_addr),
    .accept    (accept),
    .err_start (err_start),
    .rd_en     (rd_en),
    .rd_index  (rd_index),
    .wr_en     (wr_en),
    .wr_index  (wr_index),
    .wr_strobe (wr_strobe)
  );

  // ----------------------------------------
  // response and storage
  // ----------------------------------------
  ahb_resp_fsm u_resp_fsm (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .err_start (err_start),
    .HREADYout (HREADYout),
    .HRESP     (HRESP)
  );

  ahb_sram_array u_sram_array (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .wr_en     (wr_en),
    .wr_index  (wr_index),
    .wr_strobe (wr_strobe),
    .HWDATA    (HWDATA),
    .rd_en     (rd_en),
    .rd_index  (rd_index),
    .HRDATA    (HRDATA)
  );

endmodule

`default_nettype wire

// File: rtl/ahb_sram_array.sv
/*
  word sram with byte lane writes
  registered read data with same-edge write bypass
*/
`timescale 1ns/1ps
`default_nettype none
`include "ahb_sram_config.svh"

module ahb_sram_array (
  input  wire                           HCLK,
  input  wire                           HRESETn,
  input  wire                           wr_en,
  input  wire [`SRAM_INDEX_WIDTH-1:0]   wr_index,
  input  wire [3:0]                     wr_strobe,
  input  wire [`AHB_DATA_WIDTH-1:0]     HWDATA,
  input  wire                           rd_en,
  input  wire [`SRAM_INDEX_WIDTH-1:0]   rd_index,
  output logic [`AHB_DATA_WIDTH-1:0]    HRDATA
);

  // byte lanes per word
  localparam int LANES = `AHB_DATA_WIDTH / 8;

  logic [`AHB_DATA_WIDTH-1:0] mem [`SRAM_DEPTH];
  logic [`AHB_DATA_WIDTH-1:0] rd_word;

  // ----------------------------------------
  // read path
  // ----------------------------------------
  // stored word, then lanes being written on this edge
  always_comb begin
    rd_word = mem[rd_index];
    for (int b = 0; b < LANES; b++) begin
      if (wr_en && (wr_index == rd_index) && wr_strobe[b]) begin
        rd_word[8*b +: 8] = HWDATA[8*b +: 8];
      end
    end
  end

  // hrdata holds between reads
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      HRDATA <= '0;
    end else if (rd_en) begin
      HRDATA <= rd_word;
    end
  end

  // ----------------------------------------
  // write path
  // ----------------------------------------
  // whole array cleared at reset
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      for (int i = 0; i < `SRAM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      // only strobed lanes change
      for (int b = 0; b < LANES; b++) begin
        if (wr_strobe[b]) begin
          mem[wr_index][8*b +: 8] <= HWDATA[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/ahb_resp_fsm.sv
/*
  two-cycle ahb error response FSM
  drives HREADYout and HRESP
*/
`timescale 1ns/1ps
`default_nettype none

module ahb_resp_fsm (
  input  wire                   HCLK,
  input  wire                   HRESETn,
  input  wire                   err_start,
  output logic                  HREADYout,
  output ahb_sram_pkg::hresp_e  HRESP
);
  import ahb_sram_pkg::*;

  resp_state_e state;
  resp_state_e state_nxt;

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb begin
    case (state)
      RESP_OKAY: state_nxt = err_start ? RESP_ERR1 : RESP_OKAY;
      // wait state cycle, nothing is accepted here
      RESP_ERR1: state_nxt = RESP_ERR2;
      // a fresh bad beat restarts the pair
      RESP_ERR2: state_nxt = err_start ? RESP_ERR1 : RESP_OKAY;
      default:   state_nxt = RESP_OKAY;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state <= RESP_OKAY;
    end else begin
      state <= state_nxt;
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  // low only in the first error cycle
  assign HREADYout = (state != RESP_ERR1);

  // error held across both cycles
  assign HRESP = (state == RESP_OKAY) ? OKAY : ERROR;

endmodule

`default_nettype wire

// File: rtl/ahb_xfer_decode.sv
/*
  transfer accept and error check
  byte strobe decode, read request, data-phase write hold
*/
`timescale 1ns/1ps
`default_nettype none
`include "ahb_sram_config.svh"

module ahb_xfer_decode (
  input  wire                           HCLK,
  input  wire                           HRESETn,
  input  wire                           HSEL,
  input  wire ahb_sram_pkg::htrans_e    HTRANS,
  input  wire                           HWRITE,
  input  wire ahb_sram_pkg::hsize_e     HSIZE,
  input  wire                           HREADYin,
  input  wire [`AHB_ADDR_WIDTH-1:0]     beat_addr,
  output logic                          accept,
  output logic                          err_start,
  output logic                          rd_en,
  output logic [`SRAM_INDEX_WIDTH-1:0]  rd_index,
  output logic                          wr_en,
  output logic [`SRAM_INDEX_WIDTH-1:0]  wr_index,
  output logic [3:0]                    wr_strobe
);
  import ahb_sram_pkg::*;

  // word count at the width of a word address
  localparam logic [`AHB_ADDR_WIDTH-3:0] DEPTH_WORDS = `SRAM_DEPTH;

  logic       size_err;
  logic       align_err;
  logic       range_err;
  logic       good;
  logic [3:0] strobe;
  logic       wr_pend;

  // ----------------------------------------
  // address phase
  // ----------------------------------------
  assign accept = HSEL && HREADYin && ((HTRANS == NONSEQ) || (HTRANS == SEQ));

  // dword and wider never fit the 32-bit bus
  assign size_err = (HSIZE > SIZE_WORD);

  // alignment to the transfer size
  always_comb begin
    case (HSIZE)
      SIZE_HALF: align_err = beat_addr[0];
      SIZE_WORD: align_err = |beat_addr[1:0];
      default:   align_err = 1'b0;
    endcase
  end

  // word index past the end of the array
  assign range_err = (beat_addr[`AHB_ADDR_WIDTH-1:2] >= DEPTH_WORDS);

  assign err_start = accept && (size_err || align_err || range_err);
  assign good      = accept && !(size_err || align_err || range_err);

  // reads go straight to the array in the address phase
  assign rd_en    = good && !HWRITE;
  assign rd_index = beat_addr[`SRAM_INDEX_WIDTH+1:2];

  // byte lanes from size and low address bits
  always_comb begin
    case (HSIZE)
      SIZE_BYTE: strobe = 4'b0001 << beat_addr[1:0];
      SIZE_HALF: strobe = 4'b0011 << {beat_addr[1], 1'b0};
      SIZE_WORD: strobe = 4'b1111;
      default:   strobe = 4'b0000;
    endcase
  end

  // ----------------------------------------
  // data phase write
  // ----------------------------------------
  // pending flag moves only when the previous phase completes
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wr_pend <= 1'b0;
    end else if (HREADYin) begin
      wr_pend <= good && HWRITE;
    end
  end

  // index and lanes held for the data phase
  always_ff @(posedge HCLK) begin
    if (good && HWRITE) begin
      wr_index  <= beat_addr[`SRAM_INDEX_WIDTH+1:2];
      wr_strobe <= strobe;
    end
  end

  // hwdata is valid once hreadyin closes the phase
  assign wr_en = wr_pend && HREADYin;

endmodule

`default_nettype wire

// File: rtl/ahb_burst_addr.sv
/*
  beat address generator
  keeps the last accepted address, steps it for incr and wrap bursts
*/
`timescale 1ns/1ps
`default_nettype none
`include "ahb_sram_config.svh"

module ahb_burst_addr (
  input  wire                         HCLK,
  input  wire                         HRESETn,
  input  wire                         accept,
  input  wire ahb_sram_pkg::htrans_e  HTRANS,
  input  wire ahb_sram_pkg::hburst_e  HBURST,
  input  wire ahb_sram_pkg::hsize_e   HSIZE,
  input  wire [`AHB_ADDR_WIDTH-1:0]   HADDR,
  output logic [`AHB_ADDR_WIDTH-1:0]  beat_addr
);
  import ahb_sram_pkg::*;

  logic [`AHB_ADDR_WIDTH-1:0] last_addr;
  logic [`AHB_ADDR_WIDTH-1:0] incr_addr;
  logic [`AHB_ADDR_WIDTH-1:0] wrap_mask;
  logic [2:0]                 wrap_log2;
  logic [4:0]                 wrap_shift;
  logic                       is_wrap;

  // ----------------------------------------
  // wrap boundary
  // ----------------------------------------
  // log2 of beats per wrap block, 0 for incr and single
  always_comb begin
    case (HBURST)
      WRAP4:   wrap_log2 = 3'd2;
      WRAP8:   wrap_log2 = 3'd3;
      WRAP16:  wrap_log2 = 3'd4;
      default: wrap_log2 = 3'd0;
    endcase
  end

  assign is_wrap = (wrap_log2 != 3'd0);

  // boundary = beats * bytes per beat, as a shift
  assign wrap_shift = {2'b00, wrap_log2} + {2'b00, HSIZE};
  assign wrap_mask  = (`AHB_ADDR_WIDTH'(1) << wrap_shift) - `AHB_ADDR_WIDTH'(1);

  // next sequential address, step is the size in bytes
  assign incr_addr = last_addr + (`AHB_ADDR_WIDTH'(1) << HSIZE);

  // ----------------------------------------
  // beat address
  // ----------------------------------------
  always_comb begin
    if (HTRANS == SEQ) begin
      if (is_wrap) begin
        // low bits wrap inside the block, upper bits stay put
        beat_addr = (last_addr & ~wrap_mask) | (incr_addr & wrap_mask);
      end else begin
        beat_addr = incr_addr;
      end
    end else begin
      // nonseq start, idle and busy just follow the bus
      beat_addr = HADDR;
    end
  end

  // only accepted beats move the address, busy leaves it alone
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      last_addr <= '0;
    end else if (accept) begin
      last_addr <= beat_addr;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ahb_sram_pkg.sv
/*
  ahb-lite transfer, burst, size and response enums
  response state enum for the error response FSM
*/
`default_nettype none

package ahb_sram_pkg;

  // htrans encodings
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // hburst encodings, wrap and incr interleaved as on the bus
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_e;

  // hsize, everything above a word is an error here
  typedef enum logic [2:0] {
    SIZE_BYTE   = 3'b000,
    SIZE_HALF   = 3'b001,
    SIZE_WORD   = 3'b010,
    SIZE_DWORD  = 3'b011,
    SIZE_4WORD  = 3'b100,
    SIZE_8WORD  = 3'b101,
    SIZE_16WORD = 3'b110,
    SIZE_32WORD = 3'b111
  } hsize_e;

  // single bit hresp as in ahb-lite
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  // two-cycle error response states
  typedef enum logic [1:0] {
    RESP_OKAY = 2'b00,
    RESP_ERR1 = 2'b01,
    RESP_ERR2 = 2'b10
  } resp_state_e;

endpackage

`default_nettype wire

// File: rtl/ahb_sram_config.svh
/*
  bus width and memory size macros for the ahb sram subordinate
  address and data widths, word count, word index width
*/
`ifndef AHB_SRAM_CONFIG_SVH
`define AHB_SRAM_CONFIG_SVH

// ----------------------------------------
// ahb bus
// ----------------------------------------
// address bus width
`define AHB_ADDR_WIDTH 32
// data bus width, one 32-bit word
`define AHB_DATA_WIDTH 32

// ----------------------------------------
// sram
// ----------------------------------------
// number of 32-bit words
`define SRAM_DEPTH 64
// log2 of the word count
`define SRAM_INDEX_WIDTH 6

`endif
